//--- sources.f
src/ccu_pkg.sv
src/mu_cmd_if.sv
src/line_buf.sv
src/snoop_unit.sv
src/ccu_ctrl.sv
src/mem_unit.sv
src/ccu_top.sv
dv/tb_mem_model.sv
dv/tb_ccu_top.sv

//--- dv/tb_ccu_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ccu_top;
    import ccu_pkg::*;

    localparam int unsigned NoRequests = 40;
    localparam int unsigned WaitCycles = 400;
    localparam logic [15:0] LfsrSeed   = 16'd81;

    // One completed memory transfer as seen on the port
    typedef struct packed {
        logic      we;
        logic      wb;
        addr_t     addr;
        data_t     wdata;
        peer_idx_t owner;
    } xfer_t;

    logic        clk;
    logic        rst_n;
    logic        core_req;
    logic        core_ack;
    logic        core_we;
    addr_t       core_addr;
    data_t       core_wdata;
    data_t       core_rdata;
    logic        snp_req;
    logic        snp_ack;
    addr_t       snp_addr;
    logic        snp_data_valid;
    data_t       snp_data;
    logic        snp_dirty;
    peer_idx_t   snp_responder;
    logic        mem_req;
    logic        mem_ack;
    logic        mem_we;
    addr_t       mem_addr;
    data_t       mem_wdata;
    logic        mem_wb;
    peer_idx_t   mem_owner;
    data_t       mem_rdata;
    logic        cfg_dirty;
    peer_idx_t   cfg_responder;
    data_t       cfg_seed;
    logic [2:0]  cfg_snp_delay;
    logic [2:0]  cfg_mem_delay;
    logic [15:0] lfsr_q;
    data_t       snp_words[$];
    xfer_t       xfers[$];

    ccu_top u_ccu_top (
        .clk_i (clk), .rst_ni (rst_n),
        .core_req_i (core_req), .core_ack_o (core_ack), .core_we_i (core_we),
        .core_addr_i (core_addr), .core_wdata_i (core_wdata), .core_rdata_o (core_rdata),
        .snp_req_o (snp_req), .snp_ack_i (snp_ack), .snp_addr_o (snp_addr),
        .snp_data_valid_i (snp_data_valid), .snp_data_i (snp_data),
        .snp_dirty_i (snp_dirty), .snp_responder_i (snp_responder),
        .mem_req_o (mem_req), .mem_ack_i (mem_ack), .mem_we_o (mem_we),
        .mem_addr_o (mem_addr), .mem_wdata_o (mem_wdata), .mem_wb_o (mem_wb),
        .mem_owner_o (mem_owner), .mem_rdata_i (mem_rdata)
    );

    tb_mem_model u_mem_model (
        .clk_i (clk), .rst_ni (rst_n),
        .snp_req_i (snp_req), .snp_addr_i (snp_addr), .snp_ack_o (snp_ack),
        .snp_data_valid_o (snp_data_valid), .snp_data_o (snp_data),
        .snp_dirty_o (snp_dirty), .snp_responder_o (snp_responder),
        .mem_req_i (mem_req), .mem_we_i (mem_we), .mem_addr_i (mem_addr),
        .mem_wdata_i (mem_wdata), .mem_ack_o (mem_ack), .mem_rdata_o (mem_rdata),
        .cfg_dirty_i (cfg_dirty), .cfg_responder_i (cfg_responder), .cfg_seed_i (cfg_seed),
        .cfg_snp_delay_i (cfg_snp_delay), .cfg_mem_delay_i (cfg_mem_delay)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
            else fail_now($sformatf("[FAIL] %s: got %08h, expected %08h", name, got, exp));
    endtask

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // Returns at a rising edge where core_ack matches the level
    task automatic wait_core_ack(input logic level);
        int unsigned cycles;
        cycles = 0;
        @(posedge clk);
        while (core_ack !== level) begin
            if (cycles == WaitCycles) begin
                fail_now($sformatf("Timeout waiting for core_ack_o to become %0b", level));
            end
            cycles++;
            @(posedge clk);
        end
    endtask

    // Port monitor, sampled on the edge before the DUT updates
    always @(posedge clk) begin
        if (snp_data_valid) begin
            snp_words.push_back(snp_data);
        end
        if (mem_req && mem_ack) begin
            xfers.push_back('{mem_we, mem_wb, mem_addr, mem_wdata, mem_owner});
        end
    end

    // Four-phase rules on the core, snoop and memory pairs
    a_core_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(core_ack) |-> core_req)
        else fail_now("[FAIL] core_ack_o rose while core_req_i was low");
    a_core_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
        core_ack && core_req |=> core_ack)
        else fail_now($sformatf("[FAIL] core_ack_o fell early: %h", core_ack));
    a_snp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        snp_req && !snp_ack |=> snp_req && $stable(snp_addr))
        else fail_now($sformatf("[FAIL] snp_req_o/snp_addr_o changed before ack: %h %08h",
                                snp_req, snp_addr));
    a_snp_req_release: assert property (@(posedge clk) disable iff (!rst_n)
        snp_req && snp_ack |=> !snp_req)
        else fail_now($sformatf("[FAIL] snp_req_o still high after ack: %h", snp_req));
    a_snp_line_addr: assert property (@(posedge clk) disable iff (!rst_n)
        snp_req |-> snp_addr == {core_addr[AddrWidth-1:LineOffset], {LineOffset{1'b0}}})
        else fail_now($sformatf("[FAIL] snp_addr_o: got %08h for core address %08h",
                                snp_addr, core_addr));
    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req &&
            $stable({mem_we, mem_addr, mem_wdata, mem_wb, mem_owner}))
        else fail_now($sformatf("[FAIL] mem_addr_o/mem_wdata_o changed before ack: %08h %08h",
                                mem_addr, mem_wdata));
    a_mem_req_release: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && mem_ack |=> !mem_req)
        else fail_now($sformatf("[FAIL] mem_req_o still high after ack: %h", mem_req));

    task automatic check_idle_outputs();
        check_value("core_ack_o", core_ack, 0);
        check_value("snp_req_o", snp_req, 0);
        check_value("mem_req_o", mem_req, 0);
    endtask

    task automatic run_request();
        logic        we;
        logic [5:0]  word_addr;
        addr_t       addr;
        data_t       wdata;
        data_t       exp_rdata;
        int unsigned last;
        xfer_t       x;
        we            = 1'(take_bits(1));
        word_addr     = 6'(take_bits(6));
        addr          = {24'h0, word_addr, 2'b00};
        wdata         = take_bits(32);
        exp_rdata     = u_mem_model.mem_q[word_addr];
        #2;
        cfg_dirty     = 1'(take_bits(1));
        cfg_responder = peer_idx_t'(take_bits(PeerIdxWidth));
        cfg_seed      = take_bits(32);
        cfg_snp_delay = 3'(take_bits(3));
        cfg_mem_delay = 3'(take_bits(3));
        snp_words.delete();
        xfers.delete();
        core_we       = we;
        core_addr     = addr;
        core_wdata    = wdata;
        core_req      = 1'b1;
        wait_core_ack(1'b1);

        check_value("streamed snp_data_i words", snp_words.size(), cfg_dirty ? LineWords : 0);
        check_value("mem_req_o transfer count", xfers.size(), cfg_dirty ? LineWords + 1 : 1);
        // Writeback words first, ascending through the line
        if (cfg_dirty) begin
            for (int w = 0; w < LineWords; w++) begin
                x = xfers[w];
                check_value("mem_wb_o", x.wb, 1);
                check_value("mem_we_o", x.we, 1);
                check_value("mem_addr_o", x.addr,
                            {addr[AddrWidth-1:LineOffset], WordIdxWidth'(w), 2'b00});
                check_value("mem_wdata_o", x.wdata, snp_words[w]);
                check_value("mem_owner_o", x.owner, cfg_responder);
            end
        end
        last = xfers.size() - 1;
        x    = xfers[last];
        check_value("mem_wb_o", x.wb, 0);
        check_value("mem_owner_o", x.owner, 0);
        check_value("mem_we_o", x.we, we);
        check_value("mem_addr_o", x.addr, addr);
        if (we) begin
            check_value("mem_wdata_o", x.wdata, wdata);
        end else if (cfg_dirty) begin
            check_value("core_rdata_o", core_rdata, snp_words[addr[3:2]]);
        end else begin
            check_value("core_rdata_o", core_rdata, exp_rdata);
        end

        #2 core_req = 1'b0;
        wait_core_ack(1'b0);
        if (we) begin
            check_value("memory word", u_mem_model.mem_q[word_addr], wdata);
        end
    endtask

    initial begin
        lfsr_q        = LfsrSeed;
        rst_n         = 1'b0;
        core_req      = 1'b0;
        core_we       = 1'b0;
        core_addr     = '0;
        core_wdata    = '0;
        cfg_dirty     = 1'b0;
        cfg_responder = '0;
        cfg_seed      = '0;
        cfg_snp_delay = '0;
        cfg_mem_delay = '0;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_idle_outputs();
        end
        for (int n = 0; n < NoRequests; n++) begin
            run_request();
        end
        repeat (4) @(posedge clk);
        check_idle_outputs();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Peer caches seen through the snoop port
    input  logic               snp_req_i,
    input  ccu_pkg::addr_t     snp_addr_i,
    output logic               snp_ack_o,
    output logic               snp_data_valid_o,
    output ccu_pkg::data_t     snp_data_o,
    output logic               snp_dirty_o,
    output ccu_pkg::peer_idx_t snp_responder_o,
    // Main memory
    input  logic               mem_req_i,
    input  logic               mem_we_i,
    input  ccu_pkg::addr_t     mem_addr_i,
    input  ccu_pkg::data_t     mem_wdata_i,
    output logic               mem_ack_o,
    output ccu_pkg::data_t     mem_rdata_o,
    // Behaviour of the next request, picked by the testbench
    input  logic               cfg_dirty_i,
    input  ccu_pkg::peer_idx_t cfg_responder_i,
    input  ccu_pkg::data_t     cfg_seed_i,
    input  logic [2:0]         cfg_snp_delay_i,
    input  logic [2:0]         cfg_mem_delay_i
);
    import ccu_pkg::*;

    localparam int unsigned MemWords = 64;

    typedef enum logic [1:0] {SNP_IDLE, SNP_WAIT, SNP_STREAM, SNP_ACK} snp_state_e;
    typedef enum logic [1:0] {MEM_IDLE, MEM_WAIT, MEM_ACK} mem_state_e;

    data_t       mem_q [MemWords];
    data_t       peer_line [NoPeers][LineWords];
    snp_state_e  snp_state;
    mem_state_e  mem_state;
    logic [2:0]  snp_cnt;
    logic [2:0]  mem_cnt;
    int unsigned word_cnt;
    logic        line_dirty;
    peer_idx_t   line_owner;

    // Every byte address bit shows up in the initial word
    function automatic data_t fill_word(input logic [7:0] byte_addr);
        return {8'hA5, byte_addr, ~byte_addr, 8'h3C};
    endfunction

    task automatic clear_outputs();
        snp_ack_o        = 1'b0;
        snp_data_valid_o = 1'b0;
        snp_data_o       = '0;
        snp_dirty_o      = 1'b0;
        snp_responder_o  = '0;
        mem_ack_o        = 1'b0;
        mem_rdata_o      = '0;
        snp_state        = SNP_IDLE;
        mem_state        = MEM_IDLE;
    endtask

    task automatic step_snoop();
        case (snp_state)
            SNP_IDLE: begin
                if (snp_req_i) begin
                    line_dirty = cfg_dirty_i;
                    line_owner = cfg_responder_i;
                    snp_cnt    = cfg_snp_delay_i;
                    // A dirty peer holds a freshly modified copy of the line
                    if (cfg_dirty_i) begin
                        for (int w = 0; w < LineWords; w++) begin
                            peer_line[cfg_responder_i][w] =
                                cfg_seed_i ^ snp_addr_i ^ (data_t'(w) << 28);
                        end
                    end
                    snp_state = SNP_WAIT;
                end
            end
            SNP_WAIT: begin
                if (snp_cnt != 3'd0) begin
                    snp_cnt = snp_cnt - 3'd1;
                end else if (line_dirty) begin
                    snp_data_valid_o = 1'b1;
                    snp_data_o       = peer_line[line_owner][0];
                    word_cnt         = 1;
                    snp_state        = SNP_STREAM;
                end else begin
                    snp_ack_o       = 1'b1;
                    snp_dirty_o     = 1'b0;
                    snp_responder_o = line_owner;
                    snp_state       = SNP_ACK;
                end
            end
            SNP_STREAM: begin
                if (word_cnt == LineWords) begin
                    snp_data_valid_o = 1'b0;
                    snp_ack_o        = 1'b1;
                    snp_dirty_o      = 1'b1;
                    snp_responder_o  = line_owner;
                    snp_state        = SNP_ACK;
                end else begin
                    snp_data_o = peer_line[line_owner][word_cnt];
                    word_cnt   = word_cnt + 1;
                end
            end
            default: begin
                if (!snp_req_i) begin
                    snp_ack_o   = 1'b0;
                    snp_dirty_o = 1'b0;
                    snp_state   = SNP_IDLE;
                end
            end
        endcase
    endtask

    task automatic step_memory();
        case (mem_state)
            MEM_IDLE: begin
                if (mem_req_i) begin
                    mem_cnt   = cfg_mem_delay_i;
                    mem_state = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (mem_cnt != 3'd0) begin
                    mem_cnt = mem_cnt - 3'd1;
                end else begin
                    if (mem_we_i) begin
                        mem_q[mem_addr_i[7:2]] = mem_wdata_i;
                    end else begin
                        mem_rdata_o = mem_q[mem_addr_i[7:2]];
                    end
                    mem_ack_o = 1'b1;
                    mem_state = MEM_ACK;
                end
            end
            default: begin
                if (!mem_req_i) begin
                    mem_ack_o = 1'b0;
                    mem_state = MEM_IDLE;
                end
            end
        endcase
    endtask

    initial begin
        clear_outputs();
        for (int i = 0; i < MemWords; i++) begin
            mem_q[i] = fill_word(8'(i * 4));
        end
    end

    // Responds 2 ns after the edge, the DUT sees it at the next edge
    always begin
        @(posedge clk_i);
        #2;
        if (!rst_ni) begin
            clear_outputs();
        end else begin
            step_snoop();
            step_memory();
        end
    end

endmodule

`default_nettype wire

//--- src/ccu_top.sv
`timescale 1ns/100ps
`default_nettype none

module ccu_top (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Core port
    input  logic               core_req_i,
    output logic               core_ack_o,
    input  logic               core_we_i,
    input  ccu_pkg::addr_t     core_addr_i,
    input  ccu_pkg::data_t     core_wdata_i,
    output ccu_pkg::data_t     core_rdata_o,
    // Snoop port
    output logic               snp_req_o,
    input  logic               snp_ack_i,
    output ccu_pkg::addr_t     snp_addr_o,
    input  logic               snp_data_valid_i,
    input  ccu_pkg::data_t     snp_data_i,
    input  logic               snp_dirty_i,
    input  ccu_pkg::peer_idx_t snp_responder_i,
    // Memory port
    output logic               mem_req_o,
    input  logic               mem_ack_i,
    output logic               mem_we_o,
    output ccu_pkg::addr_t     mem_addr_o,
    output ccu_pkg::data_t     mem_wdata_o,
    output logic               mem_wb_o,
    output ccu_pkg::peer_idx_t mem_owner_o,
    input  ccu_pkg::data_t     mem_rdata_i
);
    import ccu_pkg::*;

    logic      snp_start;
    logic      snp_done;
    logic      snp_dirty;
    peer_idx_t snp_responder;
    logic      buf_push;
    logic      buf_pop;
    logic      buf_full;
    logic      buf_empty;
    data_t     buf_wdata;
    data_t     buf_rdata;

    mu_cmd_if mu_cmd ();

    ccu_ctrl u_ccu_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .core_req_i      (core_req_i),
        .core_ack_o      (core_ack_o),
        .core_we_i       (core_we_i),
        .core_addr_i     (core_addr_i),
        .core_wdata_i    (core_wdata_i),
        .core_rdata_o    (core_rdata_o),
        .snp_start_o     (snp_start),
        .snp_done_i      (snp_done),
        .snp_dirty_i     (snp_dirty),
        .snp_responder_i (snp_responder),
        .mu              (mu_cmd)
    );

    // Snoop address is the request latched by control
    snoop_unit u_snoop_unit (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .start_i          (snp_start),
        .addr_i           (mu_cmd.addr),
        .done_o           (snp_done),
        .dirty_o          (snp_dirty),
        .responder_o      (snp_responder),
        .snp_req_o        (snp_req_o),
        .snp_addr_o       (snp_addr_o),
        .snp_ack_i        (snp_ack_i),
        .snp_dirty_i      (snp_dirty_i),
        .snp_responder_i  (snp_responder_i),
        .snp_data_valid_i (snp_data_valid_i),
        .snp_data_i       (snp_data_i),
        .buf_full_i       (buf_full),
        .buf_push_o       (buf_push),
        .buf_data_o       (buf_wdata)
    );

    line_buf u_line_buf (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (buf_push),
        .data_i  (buf_wdata),
        .pop_i   (buf_pop),
        .data_o  (buf_rdata),
        .full_o  (buf_full),
        .empty_o (buf_empty)
    );

    mem_unit u_mem_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cmd         (mu_cmd),
        .buf_data_i  (buf_rdata),
        .buf_empty_i (buf_empty),
        .buf_pop_o   (buf_pop),
        .mem_req_o   (mem_req_o),
        .mem_ack_i   (mem_ack_i),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wb_o    (mem_wb_o),
        .mem_owner_o (mem_owner_o),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

`default_nettype wire

//--- src/mem_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mem_unit (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Command from control
    mu_cmd_if.mu               cmd,
    // Line buffer read side
    input  ccu_pkg::data_t     buf_data_i,
    input  logic               buf_empty_i,
    output logic               buf_pop_o,
    // External memory port
    output logic               mem_req_o,
    input  logic               mem_ack_i,
    output logic               mem_we_o,
    output ccu_pkg::addr_t     mem_addr_o,
    output ccu_pkg::data_t     mem_wdata_o,
    output logic               mem_wb_o,
    output ccu_pkg::peer_idx_t mem_owner_o,
    input  ccu_pkg::data_t     mem_rdata_i
);
    import ccu_pkg::*;

    logic      busy_q;
    mu_op_e    op_q;
    logic      mem_req_q;
    logic      cmd_ack_q;
    word_idx_t word_q;
    data_t     rdata_q;
    logic      is_wb;
    logic      xfer_done;
    addr_t     wb_addr;

    assign is_wb     = (op_q == MU_WB_READ) || (op_q == MU_WB_WRITE);
    assign xfer_done = mem_req_q && mem_ack_i;

    // Writeback walks the line in ascending word order
    assign wb_addr = {cmd.addr[AddrWidth-1:LineOffset], word_q, {ByteOffset{1'b0}}};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q    <= 1'b0;
            op_q      <= MU_READ;
            mem_req_q <= 1'b0;
            cmd_ack_q <= 1'b0;
            word_q    <= '0;
        end else if (!busy_q) begin
            if (cmd.req && !cmd_ack_q) begin
                busy_q <= 1'b1;
                op_q   <= cmd.op;
                word_q <= '0;
            end else if (!cmd.req) begin
                cmd_ack_q <= 1'b0;
            end
        end else if (!mem_req_q) begin
            // Previous ack must be gone, and a writeback needs a word at hand
            if (!mem_ack_i && !(is_wb && buf_empty_i)) begin
                mem_req_q <= 1'b1;
            end
        end else if (mem_ack_i) begin
            mem_req_q <= 1'b0;
            if (is_wb) begin
                word_q <= word_q + word_idx_t'(1);
                // Last line word written, fall through to the core access
                if (word_q == word_idx_t'(LineWords - 1)) begin
                    op_q <= (op_q == MU_WB_READ) ? MU_READ : MU_WRITE;
                end
            end else begin
                busy_q    <= 1'b0;
                cmd_ack_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer_done && !is_wb) begin
            rdata_q <= mem_rdata_i;
        end
    end

    assign buf_pop_o   = xfer_done && is_wb;

    assign mem_req_o   = mem_req_q;
    assign mem_we_o    = is_wb || (op_q == MU_WRITE);
    assign mem_addr_o  = is_wb ? wb_addr : cmd.addr;
    assign mem_wdata_o = is_wb ? buf_data_i : cmd.wdata;
    assign mem_wb_o    = busy_q && is_wb;
    assign mem_owner_o = mem_wb_o ? cmd.responder : '0;

    assign cmd.ack     = cmd_ack_q;
    assign cmd.rdata   = rdata_q;

    // Memory sees one steady transfer until it answers
    a_mem_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_ack_i |=> mem_req_o &&
            $stable({mem_we_o, mem_addr_o, mem_wdata_o, mem_wb_o, mem_owner_o}))
        else $error("mem_unit: memory request changed before ack");

endmodule

`default_nettype wire

//--- src/ccu_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ccu_ctrl (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Core port
    input  logic               core_req_i,
    output logic               core_ack_o,
    input  logic               core_we_i,
    input  ccu_pkg::addr_t     core_addr_i,
    input  ccu_pkg::data_t     core_wdata_i,
    output ccu_pkg::data_t     core_rdata_o,
    // Snoop unit
    output logic               snp_start_o,
    input  logic               snp_done_i,
    input  logic               snp_dirty_i,
    input  ccu_pkg::peer_idx_t snp_responder_i,
    // Memory unit command
    mu_cmd_if.ctrl             mu
);
    import ccu_pkg::*;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_SNOOP,
        CTRL_MEM_CMD,
        CTRL_WAIT_RELEASE,
        CTRL_CORE_ACK
    } ctrl_state_e;

    ctrl_state_e state_q;
    logic        snp_start_q;
    logic        mu_req_q;
    logic        core_ack_q;
    mu_op_e      op_q;
    mu_op_e      op_sel;
    logic        we_q;
    addr_t       addr_q;
    data_t       wdata_q;
    data_t       rdata_q;
    peer_idx_t   responder_q;

    // A dirty line goes to memory before the core access
    always_comb begin
        case ({we_q, snp_dirty_i})
            2'b00:   op_sel = MU_READ;
            2'b01:   op_sel = MU_WB_READ;
            2'b10:   op_sel = MU_WRITE;
            default: op_sel = MU_WB_WRITE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= CTRL_IDLE;
            snp_start_q <= 1'b0;
            mu_req_q    <= 1'b0;
            core_ack_q  <= 1'b0;
            op_q        <= MU_READ;
        end else begin
            case (state_q)
                CTRL_IDLE: begin
                    if (core_req_i && !snp_done_i) begin
                        snp_start_q <= 1'b1;
                        state_q     <= CTRL_SNOOP;
                    end
                end
                CTRL_SNOOP: begin
                    if (snp_done_i) begin
                        snp_start_q <= 1'b0;
                        op_q        <= op_sel;
                        mu_req_q    <= 1'b1;
                        state_q     <= CTRL_MEM_CMD;
                    end
                end
                CTRL_MEM_CMD: begin
                    if (mu.ack) begin
                        mu_req_q <= 1'b0;
                        state_q  <= CTRL_WAIT_RELEASE;
                    end
                end
                CTRL_WAIT_RELEASE: begin
                    // Memory unit is free again once its ack is gone
                    if (!mu.ack) begin
                        core_ack_q <= 1'b1;
                        state_q    <= CTRL_CORE_ACK;
                    end
                end
                CTRL_CORE_ACK: begin
                    if (!core_req_i) begin
                        core_ack_q <= 1'b0;
                        state_q    <= CTRL_IDLE;
                    end
                end
                default: state_q <= CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == CTRL_IDLE && core_req_i && !snp_done_i) begin
            we_q    <= core_we_i;
            addr_q  <= core_addr_i;
            wdata_q <= core_wdata_i;
        end
        if (state_q == CTRL_SNOOP && snp_done_i) begin
            responder_q <= snp_responder_i;
        end
        if (state_q == CTRL_MEM_CMD && mu.ack) begin
            rdata_q <= mu.rdata;
        end
    end

    assign snp_start_o  = snp_start_q;
    assign core_ack_o   = core_ack_q;
    assign core_rdata_o = rdata_q;

    assign mu.req       = mu_req_q;
    assign mu.op        = op_q;
    assign mu.addr      = addr_q;
    assign mu.wdata     = wdata_q;
    assign mu.responder = responder_q;

    a_ack_in_ack_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_ack_o |-> state_q == CTRL_CORE_ACK)
        else $error("ccu_ctrl: core ack outside ack state");

endmodule

`default_nettype wire

//--- src/snoop_unit.sv
`timescale 1ns/100ps
`default_nettype none

module snoop_unit (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Internal start/done pair from control
    input  logic               start_i,
    input  ccu_pkg::addr_t     addr_i,
    output logic               done_o,
    output logic               dirty_o,
    output ccu_pkg::peer_idx_t responder_o,
    // External snoop port
    output logic               snp_req_o,
    output ccu_pkg::addr_t     snp_addr_o,
    input  logic               snp_ack_i,
    input  logic               snp_dirty_i,
    input  ccu_pkg::peer_idx_t snp_responder_i,
    input  logic               snp_data_valid_i,
    input  ccu_pkg::data_t     snp_data_i,
    // Line buffer write side
    input  logic               buf_full_i,
    output logic               buf_push_o,
    output ccu_pkg::data_t     buf_data_o
);
    import ccu_pkg::*;

    typedef enum logic [1:0] {
        SNP_IDLE,
        SNP_REQ,
        SNP_DONE
    } snp_state_e;

    snp_state_e state_q;
    logic       req_q;
    logic       done_q;
    logic       dirty_q;
    peer_idx_t  responder_q;
    addr_t      line_addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= SNP_IDLE;
            req_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            case (state_q)
                SNP_IDLE: begin
                    if (start_i) begin
                        req_q   <= 1'b1;
                        state_q <= SNP_REQ;
                    end
                end
                SNP_REQ: begin
                    if (snp_ack_i) begin
                        req_q   <= 1'b0;
                        done_q  <= 1'b1;
                        state_q <= SNP_DONE;
                    end
                end
                SNP_DONE: begin
                    // Both sides must release before the next snoop
                    if (!start_i && !snp_ack_i) begin
                        done_q  <= 1'b0;
                        state_q <= SNP_IDLE;
                    end
                end
                default: state_q <= SNP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == SNP_IDLE && start_i) begin
            line_addr_q <= {addr_i[AddrWidth-1:LineOffset], {LineOffset{1'b0}}};
        end
        // Peer result is sampled together with its ack
        if (state_q == SNP_REQ && snp_ack_i) begin
            dirty_q     <= snp_dirty_i;
            responder_q <= snp_responder_i;
        end
    end

    assign snp_req_o   = req_q;
    assign snp_addr_o  = line_addr_q;
    assign done_o      = done_q;
    assign dirty_o     = dirty_q;
    assign responder_o = responder_q;

    // Line words arrive ahead of the ack
    assign buf_push_o = (state_q == SNP_REQ) && snp_data_valid_i;
    assign buf_data_o = snp_data_i;

    // The memory unit drains the buffer before control starts another snoop
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        buf_push_o |-> !buf_full_i)
        else $error("snoop_unit: push into full line buffer");

endmodule

`default_nettype wire

//--- src/line_buf.sv
`timescale 1ns/100ps
`default_nettype none

module line_buf (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           push_i,
    input  ccu_pkg::data_t data_i,
    input  logic           pop_i,
    output ccu_pkg::data_t data_o,
    output logic           full_o,
    output logic           empty_o
);
    import ccu_pkg::*;

    data_t                 mem_q [LineWords];
    word_idx_t             wr_ptr_q;
    word_idx_t             rd_ptr_q;
    logic [CountWidth-1:0] count_q;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap on their own since the depth is a power of two
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + word_idx_t'(1);
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + word_idx_t'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + CountWidth'(1);
                2'b01:   count_q <= count_q - CountWidth'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Head word only, a word pushed this cycle shows up a cycle later
    assign data_o  = mem_q[rd_ptr_q];
    assign full_o  = (count_q == CountWidth'(LineWords));
    assign empty_o = (count_q == '0);

    // Memory unit only pops words the peer has already streamed in
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o)
        else $error("line_buf: pop while empty");

endmodule

`default_nettype wire

//--- src/mu_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mu_cmd_if;
    import ccu_pkg::*;

    // Four-phase pair, fields held by control until ack rises
    logic      req;
    logic      ack;
    mu_op_e    op;
    addr_t     addr;
    data_t     wdata;
    peer_idx_t responder;
    // Valid while ack is high
    data_t     rdata;

    modport ctrl (
        output req,
        output op,
        output addr,
        output wdata,
        output responder,
        input  ack,
        input  rdata
    );

    modport mu (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        input  responder,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

//--- src/ccu_pkg.sv
`default_nettype none

package ccu_pkg;

    // Bus and system geometry
    localparam int unsigned AddrWidth = 32;
    localparam int unsigned DataWidth = 32;
    localparam int unsigned LineWords = 4;
    localparam int unsigned NoPeers   = 4;

    // Derived line geometry
    localparam int unsigned PeerIdxWidth = $clog2(NoPeers);
    localparam int unsigned WordIdxWidth = $clog2(LineWords);
    localparam int unsigned WordBytes    = DataWidth / 8;
    localparam int unsigned ByteOffset   = $clog2(WordBytes);
    localparam int unsigned LineOffset   = ByteOffset + WordIdxWidth;
    // Occupancy counter must reach LineWords itself
    localparam int unsigned CountWidth   = $clog2(LineWords + 1);

    typedef logic [AddrWidth-1:0]    addr_t;
    typedef logic [DataWidth-1:0]    data_t;
    typedef logic [PeerIdxWidth-1:0] peer_idx_t;
    typedef logic [WordIdxWidth-1:0] word_idx_t;

    // Work handed from control to the memory unit
    typedef enum logic [1:0] {
        MU_READ,
        MU_WRITE,
        MU_WB_READ,
        MU_WB_WRITE
    } mu_op_e;

endpackage

`default_nettype wire
